// File: gpio_input_sync.sv
// Pin input stage with a two-flop synchronizer and a polarity-selected edge detector per pin.
module gpio_input_sync #(
  parameter int NUM_GPIO = 16
) (
  input  logic                pclk,
  input  logic                reset_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  input  logic [NUM_GPIO-1:0] irq_pol_i,
  output logic [NUM_GPIO-1:0] pin_sync_o,
  output logic [NUM_GPIO-1:0] pin_event_o
);

  logic [NUM_GPIO-1:0] meta_q;  // First stage, may go metastable.
  logic [NUM_GPIO-1:0] sync_q;  // Second stage, safe to use.
  logic [NUM_GPIO-1:0] prev_q;  // Synchronized level one cycle ago.
  logic [NUM_GPIO-1:0] rise;    // Pin went from low to high.
  logic [NUM_GPIO-1:0] fall;    // Pin went from high to low.

  // The pins are asynchronous to pclk.
  // Two flops give the first stage a full cycle to settle.
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= gpio_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  // Edges are seen in the cycle where the synchronized level changes.
  assign rise = sync_q & ~prev_q;
  assign fall = ~sync_q & prev_q;

  // Polarity one picks the rising edge and zero the falling edge.
  // After reset every polarity bit is zero, so only falling edges count.
  assign pin_event_o = (rise & irq_pol_i) | (fall & ~irq_pol_i);

  assign pin_sync_o = sync_q;  // Two edges behind the pin.

endmodule

// File: gpio_pkg.sv
// Shared definitions for the Wishbone GPIO bridge: bus widths, register map and slave states.
package gpio_pkg;

  // The Wishbone side of the bridge is a plain 32-bit classic bus.
  typedef logic [31:0] wb_addr_t;  // Byte address from the master.
  typedef logic [31:0] wb_data_t;  // One data word in either direction.
  typedef logic [3:0]  wb_sel_t;   // One select bit per byte lane.

  // The register file only looks at the low five address bits.
  // Addresses with any higher bit set never reach a register.
  typedef logic [4:0]  reg_off_t;

  // Register map. All registers are word aligned and NUM_GPIO bits wide.
  // Bits at or above NUM_GPIO read as zero and ignore writes.

  // Output data driven onto the pins whose direction bit is set.
  localparam reg_off_t OFF_DATA_OUT = 5'h00;

  // Pin direction. A one makes the pin an output.
  localparam reg_off_t OFF_DIR      = 5'h04;

  // Synchronized pin levels. This register is read only.
  localparam reg_off_t OFF_DATA_IN  = 5'h08;

  // Interrupt enable per pin.
  localparam reg_off_t OFF_IRQ_EN   = 5'h0C;

  // Interrupt status. Writing a one clears that bit.
  localparam reg_off_t OFF_IRQ_STAT = 5'h10;

  // Edge polarity per pin. A one selects rising edges and a zero falling edges.
  localparam reg_off_t OFF_IRQ_POL  = 5'h14;

  // Wishbone slave FSM states.
  // ST_IDLE waits for cyc and stb and issues the register request.
  // ST_ACCESS waits for the register file to answer with ack or err.
  // ST_RESPOND is the free cycle that lets the master drop stb.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESPOND
  } wb_state_e;

endpackage

// File: gpio_reg_if.sv
// Internal register bus carrying one single-beat request and its answer to the GPIO registers.
interface gpio_reg_if;
  import gpio_pkg::*;

  // Request side, driven by the Wishbone front end.
  logic     req;    // High for exactly one cycle per access.
  logic     we;     // Write when high, read when low.
  reg_off_t off;    // Word offset of the addressed register.
  wb_data_t wdata;  // Write data, merged per byte lane by the target.
  wb_sel_t  sel;    // Byte lanes taking part in a write.

  // Answer side, driven by the register file one cycle after req.
  logic     ack;    // Access done.
  logic     err;    // Access refused and no state changed.
  wb_data_t rdata;  // Read data, valid while ack is high on a read.

  // The front end issues requests and samples answers.
  modport master (
    output req,
    output we,
    output off,
    output wdata,
    output sel,
    input  rdata,
    input  ack,
    input  err
  );

  // The register file takes requests and returns answers.
  modport target (
    input  req,
    input  we,
    input  off,
    input  wdata,
    input  sel,
    output rdata,
    output ack,
    output err
  );
endinterface

// File: gpio_regs.sv
// GPIO register file with byte-lane writes, read mux, edge interrupt status and interrupt line.
module gpio_regs #(
  parameter int NUM_GPIO = 16
) (
  input  logic                pclk,
  input  logic                reset_i,
  gpio_reg_if.target          reg_bus,
  input  logic [NUM_GPIO-1:0] pin_sync_i,
  input  logic [NUM_GPIO-1:0] pin_event_i,
  output logic [NUM_GPIO-1:0] irq_pol_o,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o
);
  import gpio_pkg::*;

  logic [NUM_GPIO-1:0] data_out_q;  // Output data.
  logic [NUM_GPIO-1:0] dir_q;       // Direction, one means output.
  logic [NUM_GPIO-1:0] data_in_q;   // Sampled pin levels.
  logic [NUM_GPIO-1:0] irq_en_q;    // Interrupt enables.
  logic [NUM_GPIO-1:0] irq_pol_q;   // Edge polarity.
  logic [NUM_GPIO-1:0] irq_stat_q;  // Pending interrupts.
  logic [NUM_GPIO-1:0] stat_clr;    // Status bits cleared by this write.

  wb_data_t rd_word;    // Addressed register, zero extended.
  wb_data_t new_word;   // Addressed register after the byte-lane write.
  wb_data_t clr_word;   // Write data with unselected lanes forced to zero.
  wb_data_t rdata_q;    // Registered read data.
  logic     known_off;  // The offset names a register.
  logic     access_ok;  // The access is legal.
  logic     wr_en;      // A legal write happens in this cycle.
  logic     ack_q;
  logic     err_q;

  // Replaces the selected byte lanes of a word.
  function automatic wb_data_t lane_merge(wb_data_t old_word, wb_data_t data, wb_sel_t sel);
    wb_data_t merged;
    merged = old_word;
    for (int lane = 0; lane < $bits(wb_sel_t); lane++) begin
      if (sel[lane]) begin
        merged[8*lane +: 8] = data[8*lane +: 8];
      end
    end
    return merged;
  endfunction

  // Offset decode and read mux share one case.
  always_comb begin
    known_off = 1'b1;
    case (reg_bus.off)
      OFF_DATA_OUT: rd_word = wb_data_t'(data_out_q);
      OFF_DIR:      rd_word = wb_data_t'(dir_q);
      OFF_DATA_IN:  rd_word = wb_data_t'(data_in_q);
      OFF_IRQ_EN:   rd_word = wb_data_t'(irq_en_q);
      OFF_IRQ_STAT: rd_word = wb_data_t'(irq_stat_q);
      OFF_IRQ_POL:  rd_word = wb_data_t'(irq_pol_q);
      default: begin
        known_off = 1'b0;  // Past the map or not word aligned.
        rd_word   = '0;
      end
    endcase
  end

  // DATA_IN follows the pins and refuses writes.
  assign access_ok = known_off && !(reg_bus.we && (reg_bus.off == OFF_DATA_IN));
  assign wr_en     = reg_bus.req && reg_bus.we && access_ok;

  assign new_word = lane_merge(rd_word, reg_bus.wdata, reg_bus.sel);
  assign clr_word = lane_merge('0, reg_bus.wdata, reg_bus.sel);
  assign stat_clr = (wr_en && (reg_bus.off == OFF_IRQ_STAT)) ? clr_word[NUM_GPIO-1:0] : '0;

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      data_out_q <= '0;
      dir_q      <= '0;
      data_in_q  <= '0;
      irq_en_q   <= '0;
      irq_pol_q  <= '0;
      irq_stat_q <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      data_in_q  <= pin_sync_i;
      irq_stat_q <= (irq_stat_q & ~stat_clr) | pin_event_i;  // A new event beats a clear.
      ack_q      <= reg_bus.req && access_ok;
      err_q      <= reg_bus.req && !access_ok;
      if (wr_en) begin
        case (reg_bus.off)
          OFF_DATA_OUT: data_out_q <= new_word[NUM_GPIO-1:0];
          OFF_DIR:      dir_q      <= new_word[NUM_GPIO-1:0];
          OFF_IRQ_EN:   irq_en_q   <= new_word[NUM_GPIO-1:0];
          OFF_IRQ_POL:  irq_pol_q  <= new_word[NUM_GPIO-1:0];
          default: ;  // IRQ_STAT is handled above.
        endcase
      end
    end
  end

  // Read data is captured with the request. Refused reads return zero.
  always_ff @(posedge pclk) begin
    if (reg_bus.req) begin
      rdata_q <= (access_ok && !reg_bus.we) ? rd_word : '0;
    end
  end

  assign reg_bus.rdata = rdata_q;
  assign reg_bus.ack   = ack_q;
  assign reg_bus.err   = err_q;

  assign gpio_o    = data_out_q;
  assign gpio_oe_o = dir_q;
  assign irq_pol_o = irq_pol_q;
  assign irq_o     = |(irq_stat_q & irq_en_q);  // Level interrupt from any enabled pin.

  // A request lasts one cycle, so each access writes and answers only once.
  a_single_req : assert property (@(posedge pclk) disable iff (reset_i)
    reg_bus.req |=> !reg_bus.req);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the GPIO bridge testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_wb_gpio \
  -f wb_gpio_top.f \
  -o sim_wb_gpio

./obj_dir/sim_wb_gpio > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure."
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result."
  exit 1
fi
echo "Simulation passed."

// File: tb_wb_gpio.sv
// Directed testbench for the Wishbone GPIO bridge covering registers, pin input and interrupts.
module tb_wb_gpio;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_GPIO      = 16;
  localparam int HALF_PERIOD   = 5;    // 10 ns clock.
  localparam int RESET_CYCLES  = 16;
  localparam int ANSWER_LIMIT  = 16;   // Cycles a bus cycle may wait for ack or err.
  localparam int ACCESS_COUNT  = 150;  // Bus cycles over all tests, rounded up.
  localparam int ACCESS_CYCLES = 5;    // Drive, request, answer, release and turnaround.
  localparam int IDLE_CYCLES   = 120;  // Waits while pin changes pass the synchronizer.
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES + IDLE_CYCLES);

  localparam logic [31:0] PIN_MASK = (32'h1 << NUM_GPIO) - 32'h1;  // Implemented register bits.

  // Register byte addresses, kept apart from the design package.
  localparam logic [31:0] ADR_DATA_IN  = 32'h08;
  localparam logic [31:0] ADR_IRQ_EN   = 32'h0C;
  localparam logic [31:0] ADR_IRQ_STAT = 32'h10;
  localparam logic [31:0] ADR_IRQ_POL  = 32'h14;

  logic                pclk;
  logic                reset_i;
  logic [31:0]         wb_adr;
  logic [31:0]         wb_dat_w;
  logic [3:0]          wb_sel;
  logic                wb_we;
  logic                wb_cyc;
  logic                wb_stb;
  logic [31:0]         wb_dat_r;
  logic                wb_ack;
  logic                wb_err;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic                irq;

  int          errors;       // Failed checks so far.
  logic [15:0] lfsr_q;       // Random source state.
  logic [31:0] exp_regs[6];  // Expected register values, indexed by offset / 4.

  wb_gpio_top #(.NUM_GPIO(NUM_GPIO)) i_dut (
    .pclk      (pclk),
    .reset_i   (reset_i),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat_w),
    .wb_sel_i  (wb_sel),
    .wb_we_i   (wb_we),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack),
    .wb_err_o  (wb_err),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  initial begin
    pclk = 1'b0;
    forever #HALF_PERIOD pclk = ~pclk;
  end

  // Ends a run that stopped making progress.
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge pclk);
    $display("Timeout after %0d clock cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Galois LFSR with taps 16, 14, 13 and 11, one step per bit handed out.
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] bits;
    logic        out_bit;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      out_bit = lfsr_q[0];
      lfsr_q  = lfsr_q >> 1;
      if (out_bit) begin
        lfsr_q = lfsr_q ^ 16'hB400;
      end
      bits = {bits[30:0], out_bit};
    end
    return bits;
  endfunction

  // Expands byte selects into a bit mask.
  function automatic logic [31:0] byte_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  function automatic string reg_name(input int idx);
    case (idx)
      0:       return "DATA_OUT";
      1:       return "DIR";
      2:       return "DATA_IN";
      3:       return "IRQ_EN";
      4:       return "IRQ_STAT";
      default: return "IRQ_POL";
    endcase
  endfunction

  // One classic cycle. Outputs are sampled at the falling edge, away from the driving edge.
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                           input logic [3:0] sel, output logic [31:0] rdata,
                           output logic erred);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    erred  = 1'b0;
    rdata  = '0;
    @(posedge pclk);
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    wb_sel   <= sel;
    wb_we    <= we;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    while (!acked && !erred && (waited < ANSWER_LIMIT)) begin
      @(negedge pclk);
      waited++;
      acked = wb_ack;
      erred = wb_err;
      rdata = wb_dat_r;
    end
    if (!acked && !erred) begin
      $display("Bus cycle to address %h got neither ack nor err", adr);
      errors++;
    end else begin
      // Counted from the edge where the slave first sees stb, one edge after the drive.
      compare("answer latency", 32'(waited - 1), 32'd2);
    end
    if (acked && erred) begin
      $display("Bus cycle to address %h saw ack and err together", adr);
      errors++;
    end
    @(posedge pclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] data,
                          input logic [3:0] sel, output logic erred);
    logic [31:0] ignored;
    bus_cycle(1'b1, adr, data, sel, ignored, erred);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] data,
                         output logic erred);
    bus_cycle(1'b0, adr, '0, 4'hF, data, erred);
  endtask

  task automatic write_ok(input logic [31:0] adr, input logic [31:0] data,
                          input logic [3:0] sel);
    logic erred;
    wb_write(adr, data, sel, erred);
    compare("wb_err_o", 32'(erred), 32'd0);
  endtask

  task automatic read_expect(input logic [31:0] adr, input string name,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic        erred;
    wb_read(adr, data, erred);
    compare("wb_err_o", 32'(erred), 32'd0);
    compare(name, data, exp);
  endtask

  task automatic verify_all_regs();
    for (int idx = 0; idx < 6; idx++) begin
      read_expect(32'(idx * 4), reg_name(idx), exp_regs[idx]);
    end
  endtask

  task automatic check_irq();
    @(negedge pclk);
    compare("irq_o", 32'(irq), 32'(|(exp_regs[4] & exp_regs[3])));
  endtask

  task automatic reset_state();
    @(negedge pclk);
    compare("gpio_o", 32'(gpio_out), 32'd0);
    compare("gpio_oe_o", 32'(gpio_oe), 32'd0);
    compare("irq_o", 32'(irq), 32'd0);
    verify_all_regs();
  endtask

  // Random byte-lane writes to the four writable registers, then a full readback.
  task automatic register_readback();
    logic [31:0] wdata;
    logic [31:0] rnd;
    logic [31:0] mask;
    logic [3:0]  sel;
    int          idx;
    for (int round = 0; round < 8; round++) begin
      for (int slot = 0; slot < 4; slot++) begin
        idx   = (slot < 2) ? slot : 2 * slot - 1;  // Skips DATA_IN and IRQ_STAT.
        wdata = lfsr_bits(32);
        rnd   = lfsr_bits(4);
        sel   = rnd[3:0];
        write_ok(32'(idx * 4), wdata, sel);
        mask = byte_mask(sel);
        exp_regs[idx] = ((exp_regs[idx] & ~mask) | (wdata & mask)) & PIN_MASK;
      end
      verify_all_regs();
      @(negedge pclk);
      compare("gpio_o", 32'(gpio_out), exp_regs[0]);
      compare("gpio_oe_o", 32'(gpio_oe), exp_regs[1]);
    end
  endtask

  task automatic pin_input();
    logic [31:0] pins;
    for (int round = 0; round < 6; round++) begin
      pins = lfsr_bits(NUM_GPIO);
      @(posedge pclk);
      gpio_in <= pins[NUM_GPIO-1:0];
      repeat (4) @(posedge pclk);  // Two sync flops plus the DATA_IN register.
      exp_regs[2] = pins;
      read_expect(ADR_DATA_IN, "DATA_IN", exp_regs[2]);
    end
  endtask

  task automatic edge_interrupts();
    logic [31:0] base;
    logic [31:0] pins;
    logic [31:0] clr;
    for (int round = 0; round < 4; round++) begin
      base = exp_regs[2];
      write_ok(ADR_IRQ_STAT, PIN_MASK, 4'hF);  // Drop events left by earlier pin changes.
      exp_regs[4] = '0;
      exp_regs[5] = lfsr_bits(NUM_GPIO);
      write_ok(ADR_IRQ_POL, exp_regs[5], 4'hF);
      exp_regs[3] = lfsr_bits(NUM_GPIO);
      write_ok(ADR_IRQ_EN, exp_regs[3], 4'hF);
      pins = lfsr_bits(NUM_GPIO);
      @(posedge pclk);
      gpio_in <= pins[NUM_GPIO-1:0];
      repeat (4) @(posedge pclk);
      exp_regs[2] = pins;
      // Polarity one keeps rising edges, polarity zero keeps falling edges.
      exp_regs[4] = ((pins & ~base) & exp_regs[5]) | ((base & ~pins) & ~exp_regs[5]);
      read_expect(ADR_IRQ_STAT, "IRQ_STAT", exp_regs[4]);
      check_irq();
      clr = lfsr_bits(NUM_GPIO);
      write_ok(ADR_IRQ_STAT, clr, 4'hF);
      exp_regs[4] = exp_regs[4] & ~clr;
      read_expect(ADR_IRQ_STAT, "IRQ_STAT", exp_regs[4]);
      check_irq();
      write_ok(ADR_IRQ_STAT, exp_regs[4], 4'hF);  // Clears exactly what is left.
      exp_regs[4] = '0;
      read_expect(ADR_IRQ_STAT, "IRQ_STAT", exp_regs[4]);
      check_irq();
    end
  endtask

  task automatic refused(input logic we, input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        erred;
    if (we) begin
      wb_write(adr, data, 4'hF, erred);
    end else begin
      wb_read(adr, rdata, erred);
    end
    compare("wb_err_o", 32'(erred), 32'd1);
  endtask

  task automatic illegal_access();
    logic [31:0] wdata;
    wdata = lfsr_bits(32);
    refused(1'b1, 32'h18, wdata);   // Past the last register.
    refused(1'b0, 32'h18, '0);
    refused(1'b1, 32'h100, wdata);  // Would hit DATA_OUT without bit 8.
    refused(1'b0, 32'h104, '0);
    refused(1'b1, ADR_DATA_IN, wdata);
    verify_all_regs();
    check_irq();
  endtask

  initial begin
    errors   = 0;
    lfsr_q   = 16'd14720;
    exp_regs = '{default: 32'h0};
    reset_i  <= 1'b1;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    wb_sel   <= '0;
    wb_we    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    gpio_in  <= '0;
    repeat (RESET_CYCLES) @(posedge pclk);
    reset_i <= 1'b0;
    reset_state();
    register_readback();
    pin_input();
    edge_interrupts();
    illegal_access();
    $display("Simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: wb_gpio_slave.sv
// Wishbone classic slave that turns each single-beat bus cycle into one register request.
module wb_gpio_slave (
  input  logic               pclk,
  input  logic               reset_i,
  input  gpio_pkg::wb_addr_t wb_adr_i,
  input  gpio_pkg::wb_data_t wb_dat_i,
  input  gpio_pkg::wb_sel_t  wb_sel_i,
  input  logic               wb_we_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  output gpio_pkg::wb_data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  gpio_reg_if.master         reg_bus
);
  import gpio_pkg::*;

  // Offset sent when the address has bits set above the register window.
  // It lies past the last register, so the register file refuses it.
  localparam reg_off_t OFF_OUTSIDE = '1;

  wb_state_e state_q;    // Slave FSM state.
  logic      req_q;      // One-cycle request towards the register file.
  logic      we_q;       // Captured direction.
  reg_off_t  off_q;      // Captured register offset.
  wb_data_t  wdata_q;    // Captured write data.
  wb_sel_t   sel_q;      // Captured byte selects.
  logic      new_cycle;  // A master cycle is being offered.
  logic      answered;   // The register file has answered this access.

  assign new_cycle = wb_cyc_i && wb_stb_i;
  assign answered  = reg_bus.ack || reg_bus.err;

  // Control path of the FSM.
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      req_q   <= 1'b0;
    end else begin
      req_q <= 1'b0;  // The request never lasts more than one cycle.
      case (state_q)
        ST_IDLE: begin
          if (new_cycle) begin
            state_q <= ST_ACCESS;
            req_q   <= 1'b1;
          end
        end
        ST_ACCESS: begin
          // The answer always comes one cycle after req.
          if (answered) begin
            state_q <= ST_RESPOND;
          end
        end
        ST_RESPOND: state_q <= ST_IDLE;  // Gives the master a cycle to drop stb.
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  // Access fields are captured only when a new cycle is accepted.
  always_ff @(posedge pclk) begin
    if ((state_q == ST_IDLE) && new_cycle) begin
      we_q    <= wb_we_i;
      wdata_q <= wb_dat_i;
      sel_q   <= wb_sel_i;
      // High address bits are folded into one offset that decodes as invalid.
      off_q   <= (|wb_adr_i[31:5]) ? OFF_OUTSIDE : wb_adr_i[4:0];
    end
  end

  assign reg_bus.req   = req_q;
  assign reg_bus.we    = we_q;
  assign reg_bus.off   = off_q;
  assign reg_bus.wdata = wdata_q;
  assign reg_bus.sel   = sel_q;

  // The answer goes straight to the bus. A master that already dropped cyc never sees it.
  assign wb_ack_o = (state_q == ST_ACCESS) && reg_bus.ack && wb_cyc_i;
  assign wb_err_o = (state_q == ST_ACCESS) && reg_bus.err && wb_cyc_i;
  assign wb_dat_o = reg_bus.rdata;  // Only meaningful while ack is high on a read.

  // The register file must never give both answers to one access.
  a_ack_err_excl : assert property (@(posedge pclk) disable iff (reset_i)
    !(wb_ack_o && wb_err_o));

  // The FSM waits in ST_ACCESS, so the register file must answer right after each request.
  a_answer_next : assert property (@(posedge pclk) disable iff (reset_i)
    reg_bus.req |=> answered);

endmodule

// File: wb_gpio_top.f
gpio_pkg.sv
gpio_reg_if.sv
wb_gpio_slave.sv
gpio_regs.sv
gpio_input_sync.sv
wb_gpio_top.sv
tb_wb_gpio.sv

// File: wb_gpio_top.sv
// GPIO bridge top level joining the Wishbone slave, the register file and the pin input stage.
module wb_gpio_top #(
  parameter int NUM_GPIO = 16  // Number of pins, 1 to 32.
) (
  input  logic                pclk,
  input  logic                reset_i,
  // Wishbone classic slave port.
  input  gpio_pkg::wb_addr_t  wb_adr_i,
  input  gpio_pkg::wb_data_t  wb_dat_i,
  input  gpio_pkg::wb_sel_t   wb_sel_i,
  input  logic                wb_we_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  output gpio_pkg::wb_data_t  wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o,
  // Pins and interrupt.
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o
);

  gpio_reg_if reg_bus ();  // Request and answer between slave and registers.

  logic [NUM_GPIO-1:0] pin_sync;   // Synchronized pin levels.
  logic [NUM_GPIO-1:0] pin_event;  // One-cycle edge pulses.
  logic [NUM_GPIO-1:0] irq_pol;    // Edge polarity from IRQ_POL.

  // Bus front end.
  wb_gpio_slave i_slave (
    .pclk     (pclk),
    .reset_i  (reset_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .reg_bus  (reg_bus.master)
  );

  gpio_regs #(.NUM_GPIO(NUM_GPIO)) i_regs (
    .pclk        (pclk),
    .reset_i     (reset_i),
    .reg_bus     (reg_bus.target),
    .pin_sync_i  (pin_sync),
    .pin_event_i (pin_event),
    .irq_pol_o   (irq_pol),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .irq_o       (irq_o)
  );

  gpio_input_sync #(.NUM_GPIO(NUM_GPIO)) i_input_sync (
    .pclk        (pclk),
    .reset_i     (reset_i),
    .gpio_i      (gpio_i),
    .irq_pol_i   (irq_pol),
    .pin_sync_o  (pin_sync),
    .pin_event_o (pin_event)
  );

endmodule
